// File: common/zx_defines.svh
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

////////////////////
// port decode
////////////////////

// #FE answers on every even address
`define ZX_FE_ABIT 0

// #7FFD partial decode, a15 and a1 low with a0 high
`define ZX_7FFD_AHI 15
`define ZX_7FFD_ALO 1

// #FE data fields
`define ZX_FE_BEEP_BIT 4

// #7FFD data fields
`define ZX_SCR_BIT 3
`define ZX_ROM_BIT 4
`define ZX_LOCK_BIT 5

////////////////////
// memory windows
////////////////////

// a15:a14 selects one of four 16k windows
`define ZX_WIN0 2'd0
`define ZX_WIN1 2'd1
`define ZX_WIN2 2'd2
`define ZX_WIN3 2'd3

// fixed ram pages in the middle windows
`define ZX_RAM_WIN1 3'd5
`define ZX_RAM_WIN2 3'd2

////////////////////
// interrupt timing
////////////////////

// fclk cycles per frame, shortened for simulation
`define ZX_FRAME_LEN 200

// longest int_n low time without acknowledge
`define ZX_INT_LEN 32

`endif

// File: common/zx_pkg.sv
`include "zx_defines.svh"

package zx_pkg;

	// z80 bus
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;

	// 128k layout, eight ram pages
	typedef logic [2:0] ram_page_t;

	// border colour from #FE
	typedef logic [2:0] border_t;

	// frame position, 0 to ZX_FRAME_LEN-1
	typedef logic [$clog2(`ZX_FRAME_LEN)-1:0] frame_cnt_t;

	// interrupt generator FSM
	typedef enum logic [0:0]
	{
		INT_IDLE,
		INT_ACTIVE
	} int_state_t;

endpackage

// File: zports/port_decode.sv
`timescale 1ns/1ps
`include "zx_defines.svh"

module port_decode import zx_pkg::*;
(
	input  logic   fclk,
	input  logic   arst_n,

	input  zaddr_t a,
	input  logic   iorq_n,
	input  logic   wr_n,
	input  logic   m1_n,

	output logic   wr_fe,
	output logic   wr_7ffd
);

	logic io_wr;
	logic io_wr_q;
	logic io_wr_start;
	logic hit_fe;
	logic hit_7ffd;

	////////////////////
	// bus cycle
	////////////////////

	// m1 low with iorq is an int ack and no write
	assign io_wr = !iorq_n && !wr_n && m1_n;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			io_wr_q <= 1'b0;
		else
			io_wr_q <= io_wr;
	end

	// first cycle of the write only
	assign io_wr_start = io_wr && !io_wr_q;

	////////////////////
	// address decode
	////////////////////

	// pentagon style partial decode
	assign hit_fe = !a[`ZX_FE_ABIT];

	assign hit_7ffd = !a[`ZX_7FFD_AHI] && !a[`ZX_7FFD_ALO] && a[`ZX_FE_ABIT];

	assign wr_fe = io_wr_start && hit_fe;

	assign wr_7ffd = io_wr_start && hit_7ffd;

	// never both ports in one cycle
	a_one_port: assert property (@(posedge fclk) disable iff (!arst_n)
		!(wr_fe && wr_7ffd));

endmodule

// File: zports/port_regs.sv
`timescale 1ns/1ps
`include "zx_defines.svh"

module port_regs import zx_pkg::*;
(
	input  logic    fclk,
	input  logic    arst_n,

	input  zdata_t  d,
	input  logic    wr_fe,
	input  logic    wr_7ffd,

	output border_t border,
	output logic    beep,
	output zdata_t  p7ffd
);

	logic locked;

	// lock bit sticks until reset
	assign locked = p7ffd[`ZX_LOCK_BIT];

	////////////////////
	// port #FE
	////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			border <= '0;
			beep <= 1'b0;
		end
		else if (wr_fe)
		begin
			// d[3] is tape out and not kept here
			border <= d[2:0];
			beep <= d[`ZX_FE_BEEP_BIT];
		end
	end

	////////////////////
	// port #7FFD
	////////////////////

	// pager picks the fields from the whole byte
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			p7ffd <= '0;
		else if (wr_7ffd && !locked)
			p7ffd <= d;
	end

	// paging is frozen once locked
	a_lock_holds: assert property (@(posedge fclk) disable iff (!arst_n)
		locked |=> $stable(p7ffd));

endmodule

// File: logic/mem_pager.sv
`timescale 1ns/1ps
`include "zx_defines.svh"

module mem_pager import zx_pkg::*;
(
	input  zaddr_t    a,
	input  logic      mreq_n,
	input  logic      rd_n,
	input  zdata_t    p7ffd,

	output logic      csrom,
	output logic      romoe_n,
	output logic      rom_page,
	output ram_page_t ram_page,
	output logic      scr_page
);

	logic [1:0] win;
	logic       win_rom;

	// top two address bits pick the window
	assign win = a[15:14];

	assign win_rom = (win == `ZX_WIN0);

	////////////////////
	// rom side
	////////////////////

	assign csrom = !mreq_n && win_rom;

	assign romoe_n = !(csrom && !rd_n);

	// 128 basic or 48 basic
	assign rom_page = p7ffd[`ZX_ROM_BIT];

	////////////////////
	// ram side
	////////////////////

	always_comb
	begin
		case (win)
			`ZX_WIN1: ram_page = `ZX_RAM_WIN1;
			`ZX_WIN2: ram_page = `ZX_RAM_WIN2;
			// upper window follows #7FFD
			`ZX_WIN3: ram_page = p7ffd[2:0];
			// rom window, no ram page
			default: ram_page = '0;
		endcase
	end

	// normal or shadow screen, page 5 or 7
	assign scr_page = p7ffd[`ZX_SCR_BIT];

endmodule

// File: logic/zint.sv
`timescale 1ns/1ps
`include "zx_defines.svh"

module zint import zx_pkg::*;
(
	input  logic fclk,
	input  logic arst_n,

	input  logic iorq_n,
	input  logic m1_n,

	output logic int_n
);

	localparam int LEN_W = $clog2(`ZX_INT_LEN);

	frame_cnt_t       frame_cnt;
	logic             frame_end;
	int_state_t       state;
	logic [LEN_W-1:0] len_cnt;
	logic             int_ack;
	logic             len_done;

	////////////////////
	// frame counter
	////////////////////

	assign frame_end = (frame_cnt == frame_cnt_t'(`ZX_FRAME_LEN - 1));

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			frame_cnt <= '0;
		else if (frame_end)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	////////////////////
	// int FSM
	////////////////////

	// m1 with iorq is the cpu taking the interrupt
	assign int_ack = !iorq_n && !m1_n;

	assign len_done = (len_cnt == LEN_W'(`ZX_INT_LEN - 1));

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= INT_IDLE;
			len_cnt <= '0;
		end
		else
		begin
			case (state)
				INT_IDLE:
				begin
					len_cnt <= '0;
					if (frame_end)
						state <= INT_ACTIVE;
				end
				INT_ACTIVE:
				begin
					len_cnt <= len_cnt + 1'b1;
					// released by ack or timeout, whichever first
					if (int_ack || len_done)
						state <= INT_IDLE;
				end
				default: state <= INT_IDLE;
			endcase
		end
	end

	assign int_n = (state != INT_ACTIVE);

	// int_n low for at most ZX_INT_LEN cycles
	a_int_len: assert property (@(posedge fclk) disable iff (!arst_n)
		$fell(int_n) |-> ##[1:`ZX_INT_LEN] int_n);

endmodule

// File: logic/zx_top.sv
`timescale 1ns/1ps

module zx_top import zx_pkg::*;
(
	input  logic      fclk,
	input  logic      arst_n,

	// z80
	input  logic      iorq_n,
	input  logic      mreq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  logic      m1_n,
	input  zaddr_t    a,
	input  zdata_t    d,
	output logic      int_n,

	// rom and ram paging
	output logic      csrom,
	output logic      romoe_n,
	output logic      rom_page,
	output ram_page_t ram_page,
	output logic      scr_page,

	// #FE outputs
	output logic      beep,
	output border_t   border
);

	logic   wr_fe;
	logic   wr_7ffd;
	zdata_t p7ffd;

	////////////////////
	// io ports
	////////////////////

	port_decode port_decode
	(
		.fclk    (fclk),
		.arst_n  (arst_n),
		.a       (a),
		.iorq_n  (iorq_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.wr_fe   (wr_fe),
		.wr_7ffd (wr_7ffd)
	);

	port_regs port_regs
	(
		.fclk    (fclk),
		.arst_n  (arst_n),
		.d       (d),
		.wr_fe   (wr_fe),
		.wr_7ffd (wr_7ffd),
		.border  (border),
		.beep    (beep),
		.p7ffd   (p7ffd)
	);

	////////////////////
	// memory map
	////////////////////

	mem_pager mem_pager
	(
		.a        (a),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.p7ffd    (p7ffd),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rom_page (rom_page),
		.ram_page (ram_page),
		.scr_page (scr_page)
	);

	////////////////////
	// frame interrupt
	////////////////////

	zint zint
	(
		.fclk   (fclk),
		.arst_n (arst_n),
		.iorq_n (iorq_n),
		.m1_n   (m1_n),
		.int_n  (int_n)
	);

endmodule

// File: tb/tb_zx.sv
`timescale 1ns/1ps
`include "zx_defines.svh"

module tb_zx import zx_pkg::*;
();

	typedef enum int
	{
		ROW_IO_WRITE,
		ROW_MEM_READ,
		ROW_INT_ACK,
		ROW_IDLE
	} row_kind_t;

	// exp_ram only matters on mem_read rows
	typedef struct
	{
		row_kind_t kind;
		zaddr_t    addr;
		zdata_t    data;
		ram_page_t exp_ram;
	} row_t;

	logic      fclk;
	logic      arst_n;
	logic      iorq_n;
	logic      mreq_n;
	logic      rd_n;
	logic      wr_n;
	logic      m1_n;
	zaddr_t    a;
	zdata_t    d;
	logic      int_n;
	logic      csrom;
	logic      romoe_n;
	logic      rom_page;
	logic      beep;
	logic      scr_page;
	ram_page_t ram_page;
	border_t   border;

	row_t      rows[$];

	// reference copy of the port registers
	border_t   m_border;
	logic      m_beep;
	zdata_t    m_p7ffd;

	int        errors;
	int        tests;
	int        failed_tests;

	zx_top dut0
	(
		.fclk     (fclk),
		.arst_n   (arst_n),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.a        (a),
		.d        (d),
		.int_n    (int_n),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rom_page (rom_page),
		.ram_page (ram_page),
		.scr_page (scr_page),
		.beep     (beep),
		.border   (border)
	);

	initial
		fclk = 1'b0;

	always #10 fclk = ~fclk;

	////////////////////
	// helpers
	////////////////////

	task automatic add_row(row_kind_t kind, zaddr_t addr, zdata_t data, ram_page_t exp_ram);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.data = data;
		r.exp_ram = exp_ram;
		rows.push_back(r);
	endtask

	task automatic bus_idle();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		a = '0;
		d = '0;
	endtask

	task automatic mismatch(string what, int got, int exp);
		$display("Fail at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		errors++;
	endtask

	task automatic finish_test(string name, int start_errors);
		tests++;
		if (errors == start_errors)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - start_errors);
		end
	endtask

	// #FE on any even port, #7FFD on a15 = a1 = 0 with a0 = 1
	task automatic update_model(zaddr_t addr, zdata_t data);
		if (!addr[0])
		begin
			m_border = data[2:0];
			m_beep = data[4];
		end
		else if (!addr[15] && !addr[1] && !m_p7ffd[`ZX_LOCK_BIT])
			m_p7ffd = data;
	endtask

	task automatic check_regs();
		if (border !== m_border)
			mismatch("border", int'(border), int'(m_border));
		if (beep !== m_beep)
			mismatch("beep", int'(beep), int'(m_beep));
		if (rom_page !== m_p7ffd[4])
			mismatch("rom_page", int'(rom_page), int'(m_p7ffd[4]));
		if (scr_page !== m_p7ffd[3])
			mismatch("scr_page", int'(scr_page), int'(m_p7ffd[3]));
	endtask

	// counts falling edges until int_n reaches level or limit runs out
	task automatic wait_int(logic level, int limit, output int cycles);
		cycles = 0;
		while (int_n !== level && cycles < limit)
		begin
			@(negedge fclk);
			cycles++;
		end
	endtask

	task automatic apply_row(row_t r);
		logic exp_cs;
		exp_cs = (r.addr[15:14] == 2'd0);
		@(posedge fclk);
		#2;
		a = r.addr;
		d = r.data;
		case (r.kind)
			ROW_IO_WRITE:
			begin
				iorq_n = 1'b0;
				wr_n = 1'b0;
			end
			// wr_n low too, so only m1_n keeps the port decode off
			ROW_INT_ACK:
			begin
				iorq_n = 1'b0;
				m1_n = 1'b0;
				wr_n = 1'b0;
			end
			ROW_MEM_READ:
			begin
				mreq_n = 1'b0;
				rd_n = 1'b0;
			end
			// rd_n alone must not open the rom
			default: rd_n = 1'b0;
		endcase
		if (r.kind == ROW_IO_WRITE || r.kind == ROW_INT_ACK)
		begin
			repeat (2) @(posedge fclk);
			#2;
			bus_idle();
		end
		if (r.kind == ROW_IO_WRITE)
			update_model(r.addr, r.data);
		@(negedge fclk);
		if (r.kind == ROW_MEM_READ)
		begin
			if (csrom !== exp_cs)
				mismatch("csrom", int'(csrom), int'(exp_cs));
			if (romoe_n !== !exp_cs)
				mismatch("romoe_n", int'(romoe_n), int'(!exp_cs));
			if (ram_page !== r.exp_ram)
				mismatch("ram_page", int'(ram_page), int'(r.exp_ram));
		end
		else
		begin
			if (csrom !== 1'b0)
				mismatch("csrom", int'(csrom), 0);
			if (romoe_n !== 1'b1)
				mismatch("romoe_n", int'(romoe_n), 1);
		end
		check_regs();
		@(posedge fclk);
		#2;
		bus_idle();
	endtask

	////////////////////
	// stimulus table
	////////////////////

	task automatic load_table();
		add_row(ROW_IO_WRITE, 16'h00FE, 8'h15, 3'd0);
		add_row(ROW_IO_WRITE, 16'h00FE, 8'h02, 3'd0);
		add_row(ROW_MEM_READ, 16'h0000, 8'h00, 3'd0);
		add_row(ROW_MEM_READ, 16'h4000, 8'h00, `ZX_RAM_WIN1);
		add_row(ROW_MEM_READ, 16'h8000, 8'h00, `ZX_RAM_WIN2);
		add_row(ROW_MEM_READ, 16'hC000, 8'h00, 3'd0);
		// page 3, shadow screen, rom 1
		add_row(ROW_IO_WRITE, 16'h7FFD, 8'h1B, 3'd0);
		add_row(ROW_MEM_READ, 16'hC123, 8'h00, 3'd3);
		add_row(ROW_MEM_READ, 16'h1234, 8'h00, 3'd0);
		add_row(ROW_MEM_READ, 16'h5555, 8'h00, `ZX_RAM_WIN1);
		add_row(ROW_MEM_READ, 16'hABCD, 8'h00, `ZX_RAM_WIN2);
		add_row(ROW_IDLE, 16'h0000, 8'h00, 3'd0);
		// neither port decodes these
		add_row(ROW_IO_WRITE, 16'h00FF, 8'h07, 3'd0);
		add_row(ROW_IO_WRITE, 16'h7FFF, 8'h07, 3'd0);
		add_row(ROW_INT_ACK, 16'h00FE, 8'h07, 3'd0);
		// page 6 with the lock bit set
		add_row(ROW_IO_WRITE, 16'h7FFD, 8'h26, 3'd0);
		add_row(ROW_MEM_READ, 16'hFFFF, 8'h00, 3'd6);
		add_row(ROW_MEM_READ, 16'h0100, 8'h00, 3'd0);
		add_row(ROW_IO_WRITE, 16'h7FFD, 8'h19, 3'd0);
		add_row(ROW_MEM_READ, 16'hC000, 8'h00, 3'd6);
		add_row(ROW_MEM_READ, 16'h3FFF, 8'h00, 3'd0);
		add_row(ROW_IO_WRITE, 16'h00FE, 8'h14, 3'd0);
		add_row(ROW_MEM_READ, 16'h8000, 8'h00, `ZX_RAM_WIN2);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		int start_errors;
		int cycles;
		int unsigned gap;
		void'($urandom(90));
		bus_idle();
		arst_n = 1'b0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		m_border = '0;
		m_beep = 1'b0;
		m_p7ffd = '0;
		load_table();
		repeat (3) @(posedge fclk);
		#2;
		arst_n = 1'b1;

		// first frame interrupt
		start_errors = errors;
		wait_int(1'b0, `ZX_FRAME_LEN + 20, cycles);
		if (int_n !== 1'b0)
		begin
			$display("int_n never went low after reset");
			errors++;
		end
		else if (cycles < `ZX_FRAME_LEN || cycles > `ZX_FRAME_LEN + 4)
			mismatch("cycles to first int_n low", cycles, `ZX_FRAME_LEN);
		finish_test("first interrupt", start_errors);

		// left alone, int_n times out
		start_errors = errors;
		wait_int(1'b1, `ZX_INT_LEN + 10, cycles);
		if (int_n !== 1'b1)
		begin
			$display("int_n stayed low and never returned high");
			errors++;
		end
		else if (cycles > `ZX_INT_LEN)
			mismatch("int_n low cycles", cycles, `ZX_INT_LEN);
		finish_test("interrupt length", start_errors);

		foreach (rows[i])
		begin
			start_errors = errors;
			apply_row(rows[i]);
			finish_test($sformatf("%s %04h", rows[i].kind.name(), rows[i].addr), start_errors);
			gap = $urandom_range(4, 1);
			repeat (gap) @(posedge fclk);
		end

		// next frame, released by acknowledge
		start_errors = errors;
		wait_int(1'b1, `ZX_INT_LEN + 10, cycles);
		wait_int(1'b0, `ZX_FRAME_LEN + 10, cycles);
		if (int_n !== 1'b0)
		begin
			$display("int_n did not go low on the next frame");
			errors++;
		end
		else
		begin
			@(posedge fclk);
			#2;
			iorq_n = 1'b0;
			m1_n = 1'b0;
			wait_int(1'b1, 3, cycles);
			if (int_n !== 1'b1)
			begin
				$display("int_n was not released by the acknowledge cycle");
				errors++;
			end
			else if (cycles > 2)
				mismatch("cycles from acknowledge to int_n high", cycles, 2);
			@(posedge fclk);
			#2;
			bus_idle();
		end
		finish_test("interrupt acknowledge", start_errors);

		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+common
common/zx_pkg.sv
zports/port_decode.sv
zports/port_regs.sv
logic/mem_pager.sv
logic/zint.sv
logic/zx_top.sv
tb/tb_zx.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -f tb.f --top-module tb_zx -Mdir build/obj -o tb_zx
./build/obj/tb_zx | tee build/sim.log

if grep -q "ALL CHECKS PASSED" build/sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
